//--- vlog.f
src/video_pkg.sv
src/game_pkg.sv
src/object_table.sv
src/fill_drawer.sv
src/sprite_drawer.sv
src/pixel_mux.sv
src/round_timer.sv
src/scene_sequencer.sv
src/draw_scene_top.sv
sim/tb_draw_scene.sv
+incdir+sim

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, exit status 1 on any failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps -f vlog.f \
	--top-module tb_draw_scene -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_draw_scene > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0

//--- sim/tb_tasks.svh
/*
 * helper tasks and directed tests, included inside tb_draw_scene
 * inputs change on the falling edge; frames wait on frame_ack with a timeout
 */

task automatic note_failure();
	err_count++;
	test_errs++;
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
	checks_done++;
	assert (got == want) else begin
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, want);
		note_failure();
	end
endtask

task automatic report_error(input string msg);
	$display("ERROR in %s: %s", test_name, msg);
	note_failure();
endtask

task automatic start_test(input string name);
	test_name = name;
	test_errs = 0;
	tests_run++;
endtask

task automatic finish_test();
	if (test_errs == 0) begin
		$display("test %s: ok", test_name);
	end else begin
		tests_failed++;
		$display("test %s: %0d failed checks", test_name, test_errs);
	end
endtask

task automatic write_object(input int idx, input int x, input int y, input int kind,
		input bit vis);
	logic [OBJ_W-1:0] w;
	w = '0;
	w[OBJ_X_LSB +: X_W]       = X_W'(x);
	w[OBJ_Y_LSB +: Y_W]       = Y_W'(y);
	w[OBJ_KIND_LSB +: KIND_W] = KIND_W'(kind);
	w[OBJ_VIS_BIT]            = vis;
	@(negedge clk);
	obj_we    = 1'b1;
	obj_addr  = IDX_W'(idx);
	obj_wdata = w;
	@(negedge clk);
	obj_we    = 1'b0;
	m_x[idx]    = x;
	m_y[idx]    = y;
	m_kind[idx] = kind;
	m_vis[idx]  = vis;
endtask

task automatic clear_objects();
	for (int i = 0; i < N_OBJ; i++) begin
		write_object(i, 0, 0, 0, 1'b0);
	end
endtask

// every kind code appears, entries 2 and 5 stay hidden
task automatic place_random_objects();
	int x;
	int y;
	for (int i = 0; i < N_OBJ; i++) begin
		x = {$random(seed)} % (SCREEN_W - SPRITE_SIZE + 1);
		y = {$random(seed)} % (SCREEN_H - SPRITE_SIZE + 1);
		write_object(i, x, y, i % 4, (i % 3) != 2);
	end
endtask

task automatic restart_round();
	@(negedge clk);
	round_restart = 1'b1;
	@(negedge clk);
	round_restart = 1'b0;
endtask

// one frame through the full four-phase handshake
task automatic run_frame();
	int cycles;
	@(negedge clk);
	fb_clear = 1'b1;
	@(negedge clk);
	fb_clear = 1'b0;
	check_value("frame_ack", 32'(frame_ack), 32'h0);
	frame_req = 1'b1;
	cycles = 0;
	while (!frame_ack && cycles < FRAME_CYCLES) begin
		@(negedge clk);
		cycles++;
	end
	if (!frame_ack) begin
		report_error("frame_ack did not rise within the frame time");
	end else begin
		@(negedge clk);
		check_value("frame_ack", 32'(frame_ack), 32'h1);
	end
	frame_req = 1'b0;
	cycles = 0;
	while (frame_ack && cycles < 10) begin
		@(negedge clk);
		cycles++;
	end
	if (frame_ack) begin
		report_error("frame_ack stayed high after frame_req fell");
	end
endtask

// paint the expected picture from the object mirror
task automatic build_expected(input bit game_over, output int writes);
	int last;
	logic [COLOR_W-1:0] c;
	last   = SPRITE_SIZE - 1;
	writes = NPIX;
	for (int i = 0; i < NPIX; i++) begin
		exp_img[i] = game_over ? GAMEOVER_COLOR : BG_COLOR;
	end
	for (int i = 0; i < N_OBJ; i++) begin
		if (!game_over && m_vis[i]) begin
			if (m_kind[i] == int'(KIND_GOLD)) begin
				c = GOLD_COLOR;
			end else if (m_kind[i] == int'(KIND_DIAMOND)) begin
				c = DIAMOND_COLOR;
			end else begin
				c = STONE_COLOR;
			end
			for (int dy = 0; dy < SPRITE_SIZE; dy++) begin
				for (int dx = 0; dx < SPRITE_SIZE; dx++) begin
					if (!((dx == 0 || dx == last) && (dy == 0 || dy == last))) begin
						exp_img[(m_y[i] + dy) * SCREEN_W + m_x[i] + dx] = c;
					end
				end
			end
			writes = writes + SPRITE_SIZE * SPRITE_SIZE - 4;
		end
	end
endtask

task automatic compare_frame(input int exp_writes);
	for (int i = 0; i < NPIX; i++) begin
		check_value($sformatf("fb[x=%0d,y=%0d]", i % SCREEN_W, i / SCREEN_W),
			32'(fb[i]), 32'(exp_img[i]));
	end
	check_value("pixel write count", 32'(wr_count), 32'(exp_writes));
	check_value("off-screen write count", 32'(bad_writes), 32'h0);
endtask

task automatic check_reset_state();
	start_test("reset state");
	check_value("pix_we", 32'(pix_we), 32'h0);
	check_value("frame_ack", 32'(frame_ack), 32'h0);
	check_value("time_remain", 32'(time_remain), 32'(ROUND_TIME));
	check_value("time_up", 32'(time_up), 32'h0);
	finish_test();
endtask

task automatic draw_empty_scene();
	int writes;
	start_test("empty scene");
	run_frame();
	build_expected(1'b0, writes);
	compare_frame(NPIX);
	finish_test();
endtask

task automatic draw_sprites();
	int writes;
	start_test("sprites and transparency");
	restart_round();
	place_random_objects();
	run_frame();
	build_expected(1'b0, writes);
	compare_frame(writes);
	finish_test();
endtask

task automatic draw_overlap();
	int writes;
	start_test("overlap order");
	restart_round();
	clear_objects();
	write_object(2, 5, 5, int'(KIND_STONE), 1'b1);
	write_object(5, 7, 6, int'(KIND_DIAMOND), 1'b1);
	run_frame();
	build_expected(1'b0, writes);
	compare_frame(writes);
	// stone is also under this pixel, the higher index wins
	check_value("fb[x=8,y=7]", 32'(fb[7 * SCREEN_W + 8]), 32'(DIAMOND_COLOR));
	finish_test();
endtask

task automatic run_out_of_time();
	int prev;
	int cycles;
	int writes;
	start_test("time-out");
	prev   = int'(time_remain);
	cycles = 0;
	while (!time_up && cycles < ROUND_TIME * TICK_CYCLES + 10) begin
		@(negedge clk);
		cycles++;
		assert (int'(time_remain) <= prev) else begin
			$display("CHECK FAILED: time_remain rose from 0x%0h to 0x%0h", prev, time_remain);
			note_failure();
		end
		prev = int'(time_remain);
	end
	if (!time_up) begin
		report_error("round timer did not run out in time");
	end
	check_value("time_remain", 32'(time_remain), 32'h0);
	check_value("time_up", 32'(time_up), 32'h1);
	run_frame();
	build_expected(1'b1, writes);
	compare_frame(writes);
	finish_test();
endtask

task automatic restart_and_redraw();
	int writes;
	start_test("restart");
	restart_round();
	check_value("time_remain", 32'(time_remain), 32'(ROUND_TIME));
	check_value("time_up", 32'(time_up), 32'h0);
	place_random_objects();
	run_frame();
	build_expected(1'b0, writes);
	compare_frame(writes);
	finish_test();
endtask

//--- sim/tb_draw_scene.sv
/*
 * testbench for the scene drawing core on a 32x24 screen with 4x4 sprites
 * a frame-buffer model records every pixel write; directed tests in tb_tasks.svh
 */
`timescale 1ns/100ps

module tb_draw_scene;
	import video_pkg::*;
	import game_pkg::*;

	localparam int SCREEN_W    = 32;
	localparam int SCREEN_H    = 24;
	localparam int N_OBJ       = 8;
	localparam int SPRITE_SIZE = 4;
	localparam int TICK_CYCLES = 200;
	localparam int ROUND_TIME  = 10;
	localparam int IDX_W       = $clog2(N_OBJ);
	localparam int TIME_W      = $clog2(ROUND_TIME + 1);
	localparam int NPIX        = SCREEN_W * SCREEN_H;
	localparam int CLK_PERIOD  = 10;

	// worst case for one frame, and the whole run
	localparam int FRAME_CYCLES    = NPIX + N_OBJ * SPRITE_SIZE * SPRITE_SIZE + 50;
	localparam int N_FRAMES        = 5;
	localparam int WATCHDOG_CYCLES = N_FRAMES * FRAME_CYCLES + 2 * ROUND_TIME * TICK_CYCLES;

	logic               clk;
	logic               resetn;
	logic               obj_we;
	logic [IDX_W-1:0]   obj_addr;
	logic [OBJ_W-1:0]   obj_wdata;
	logic               frame_req;
	logic               round_restart;
	logic               frame_ack;
	logic [X_W-1:0]     pix_x;
	logic [Y_W-1:0]     pix_y;
	logic [COLOR_W-1:0] pix_color;
	logic               pix_we;
	logic [TIME_W-1:0]  time_remain;
	logic               time_up;

	// frame buffer and the picture it should hold
	logic [COLOR_W-1:0] fb [NPIX];
	logic [COLOR_W-1:0] exp_img [NPIX];
	logic               fb_clear;
	int                 wr_count;
	int                 bad_writes;

	// mirror of the object table contents
	int m_x [N_OBJ];
	int m_y [N_OBJ];
	int m_kind [N_OBJ];
	bit m_vis [N_OBJ];

	integer seed;
	int     err_count;
	int     checks_done;
	int     test_errs;
	int     tests_run;
	int     tests_failed;
	string  test_name;

	draw_scene_top #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .N_OBJ(N_OBJ),
		.SPRITE_SIZE(SPRITE_SIZE), .TICK_CYCLES(TICK_CYCLES), .ROUND_TIME(ROUND_TIME)
	) UUT (
		.clk(clk), .resetn(resetn),
		.obj_we(obj_we), .obj_addr(obj_addr), .obj_wdata(obj_wdata),
		.frame_req(frame_req), .round_restart(round_restart), .frame_ack(frame_ack),
		.pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color), .pix_we(pix_we),
		.time_remain(time_remain), .time_up(time_up)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// registered pixel port, so sample on the rising edge
	always @(posedge clk) begin
		if (fb_clear) begin
			for (int i = 0; i < NPIX; i++) begin
				fb[i] = TRANSPARENT;
			end
			wr_count   = 0;
			bad_writes = 0;
		end else if (pix_we) begin
			if (int'(pix_x) < SCREEN_W && int'(pix_y) < SCREEN_H) begin
				fb[int'(pix_y) * SCREEN_W + int'(pix_x)] = pix_color;
			end else begin
				bad_writes++;
			end
			wr_count++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	`include "tb_tasks.svh"

	initial begin
		clk           = 1'b0;
		resetn        = 1'b0;
		obj_we        = 1'b0;
		obj_addr      = '0;
		obj_wdata     = '0;
		frame_req     = 1'b0;
		round_restart = 1'b0;
		fb_clear      = 1'b0;
		seed          = 32'hb76a_f5a2;
		err_count     = 0;
		checks_done   = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		check_reset_state();
		draw_empty_scene();
		draw_sprites();
		draw_overlap();
		run_out_of_time();
		restart_and_redraw();

		$display("tests run %0d, tests failed %0d, checks %0d, failed checks %0d",
			tests_run, tests_failed, checks_done, err_count);
		if (err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- src/draw_scene_top.sv
/*
 * scene drawing core: object table, sequencer, two drawers, pixel port, timer
 * objects must lie fully on screen; no object writes between frame_req and frame_ack
 */
`timescale 1ns/100ps

module draw_scene_top #(
	parameter int SCREEN_W    = video_pkg::MAX_SCREEN_W,
	parameter int SCREEN_H    = video_pkg::MAX_SCREEN_H,
	parameter int N_OBJ       = 8,
	parameter int SPRITE_SIZE = 16,
	parameter int TICK_CYCLES = 50_000_000,
	parameter int ROUND_TIME  = 60,
	localparam int IDX_W  = $clog2(N_OBJ),
	localparam int TIME_W = $clog2(ROUND_TIME + 1)
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          obj_we,
	input  logic [IDX_W-1:0]              obj_addr,
	input  logic [game_pkg::OBJ_W-1:0]    obj_wdata,
	input  logic                          frame_req,
	input  logic                          round_restart,
	output logic                          frame_ack,
	output logic [video_pkg::X_W-1:0]     pix_x,
	output logic [video_pkg::Y_W-1:0]     pix_y,
	output logic [video_pkg::COLOR_W-1:0] pix_color,
	output logic                          pix_we,
	output logic [TIME_W-1:0]             time_remain,
	output logic                          time_up
);
	import video_pkg::*;
	import game_pkg::*;

	logic               busy;
	logic [IDX_W-1:0]   obj_index;
	logic [OBJ_W-1:0]   obj_word;

	logic               fill_req;
	logic               fill_ack;
	logic [COLOR_W-1:0] fill_color;
	logic               spr_req;
	logic               spr_ack;

	logic               fill_px_valid;
	logic [X_W-1:0]     fill_px_x;
	logic [Y_W-1:0]     fill_px_y;
	logic [COLOR_W-1:0] fill_px_color;
	logic               spr_px_valid;
	logic [X_W-1:0]     spr_px_x;
	logic [Y_W-1:0]     spr_px_y;
	logic [COLOR_W-1:0] spr_px_color;

	object_table #(.N_OBJ(N_OBJ)) u_table (
		.clk(clk), .resetn(resetn),
		.obj_we(obj_we), .obj_addr(obj_addr), .obj_wdata(obj_wdata),
		.obj_index(obj_index), .obj_word(obj_word), .busy(busy)
	);

	scene_sequencer #(.N_OBJ(N_OBJ)) u_seq (
		.clk(clk), .resetn(resetn),
		.frame_req(frame_req), .frame_ack(frame_ack), .time_up(time_up),
		.fill_req(fill_req), .fill_ack(fill_ack), .fill_color(fill_color),
		.spr_req(spr_req), .spr_ack(spr_ack),
		.obj_index(obj_index), .obj_word(obj_word), .busy(busy)
	);

	fill_drawer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_fill (
		.clk(clk), .resetn(resetn),
		.fill_req(fill_req), .fill_color(fill_color), .fill_ack(fill_ack),
		.px_valid(fill_px_valid), .px_x(fill_px_x), .px_y(fill_px_y),
		.px_color(fill_px_color)
	);

	sprite_drawer #(.SPRITE_SIZE(SPRITE_SIZE)) u_sprite (
		.clk(clk), .resetn(resetn),
		.spr_req(spr_req), .obj_word(obj_word), .spr_ack(spr_ack),
		.px_valid(spr_px_valid), .px_x(spr_px_x), .px_y(spr_px_y),
		.px_color(spr_px_color)
	);

	pixel_mux u_mux (
		.clk(clk), .resetn(resetn),
		.fill_px_valid(fill_px_valid), .fill_px_x(fill_px_x),
		.fill_px_y(fill_px_y), .fill_px_color(fill_px_color),
		.spr_px_valid(spr_px_valid), .spr_px_x(spr_px_x),
		.spr_px_y(spr_px_y), .spr_px_color(spr_px_color),
		.pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color), .pix_we(pix_we)
	);

	round_timer #(.TICK_CYCLES(TICK_CYCLES), .ROUND_TIME(ROUND_TIME)) u_timer (
		.clk(clk), .resetn(resetn),
		.round_restart(round_restart),
		.time_remain(time_remain), .time_up(time_up)
	);

endmodule

//--- src/scene_sequencer.sv
/*
 * frame FSM: background fill, then each visible object in index order
 * time_up is sampled once per frame; in game-over only the fill is drawn
 * frame_ack rises one cycle after the last drawer ack and holds until frame_req falls
 */
`timescale 1ns/100ps

module scene_sequencer #(
	parameter int N_OBJ = 8,
	localparam int IDX_W = $clog2(N_OBJ)
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          frame_req,
	output logic                          frame_ack,
	input  logic                          time_up,
	output logic                          fill_req,
	input  logic                          fill_ack,
	output logic [video_pkg::COLOR_W-1:0] fill_color,
	output logic                          spr_req,
	input  logic                          spr_ack,
	output logic [IDX_W-1:0]              obj_index,
	input  logic [game_pkg::OBJ_W-1:0]    obj_word,
	output logic                          busy
);
	import video_pkg::*;
	import game_pkg::*;

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_FILL  = 3'd1;
	localparam logic [2:0] S_SCAN  = 3'd2;
	localparam logic [2:0] S_SPR   = 3'd3;
	localparam logic [2:0] S_DRAIN = 3'd4;
	localparam logic [2:0] S_ACK   = 3'd5;

	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(N_OBJ - 1);

	logic [2:0] state;
	logic       game_over;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= S_IDLE;
			frame_ack <= 1'b0;
			fill_req  <= 1'b0;
			spr_req   <= 1'b0;
			busy      <= 1'b0;
			game_over <= 1'b0;
			obj_index <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (frame_req) begin
						game_over <= time_up;
						fill_req  <= 1'b1;
						busy      <= 1'b1;
						obj_index <= '0;
						state     <= S_FILL;
					end
				end
				S_FILL: begin
					if (fill_ack) begin
						fill_req <= 1'b0;
						state    <= game_over ? S_DRAIN : S_SCAN;
					end
				end
				S_SCAN: begin
					// previous sprite must finish its handshake first
					if (!spr_ack) begin
						if (obj_word[OBJ_VIS_BIT]) begin
							spr_req <= 1'b1;
							state   <= S_SPR;
						end else if (obj_index == IDX_LAST) begin
							state <= S_DRAIN;
						end else begin
							obj_index <= obj_index + 1'b1;
						end
					end
				end
				S_SPR: begin
					if (spr_ack) begin
						spr_req <= 1'b0;
						if (obj_index == IDX_LAST) begin
							state <= S_DRAIN;
						end else begin
							obj_index <= obj_index + 1'b1;
							state     <= S_SCAN;
						end
					end
				end
				S_DRAIN: begin
					// last pixel has passed the output register by now
					if (!fill_ack && !spr_ack) begin
						frame_ack <= 1'b1;
						busy      <= 1'b0;
						state     <= S_ACK;
					end
				end
				S_ACK: begin
					if (!frame_req) begin
						frame_ack <= 1'b0;
						state     <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// fill colour is chosen once per frame
	always_ff @(posedge clk) begin
		if (state == S_IDLE && frame_req) begin
			fill_color <= time_up ? GAMEOVER_COLOR : BG_COLOR;
		end
	end

endmodule

//--- src/round_timer.sv
/*
 * round countdown in ticks of TICK_CYCLES clocks, TICK_CYCLES at least 2
 * reloads at reset and on round_restart, stops at zero
 */
`timescale 1ns/100ps

module round_timer #(
	parameter int TICK_CYCLES = 50_000_000,
	parameter int ROUND_TIME  = 60,
	localparam int TIME_W = $clog2(ROUND_TIME + 1)
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              round_restart,
	output logic [TIME_W-1:0] time_remain,
	output logic              time_up
);
	localparam int TICK_W = $clog2(TICK_CYCLES);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CYCLES - 1);

	logic [TICK_W-1:0] tick_cnt;

	always_ff @(posedge clk) begin
		if (!resetn || round_restart) begin
			tick_cnt    <= '0;
			time_remain <= TIME_W'(ROUND_TIME);
		end else if (time_remain != '0) begin
			if (tick_cnt == TICK_LAST) begin
				tick_cnt    <= '0;
				time_remain <= time_remain - 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	assign time_up = (time_remain == '0);

	// restart is a single-cycle pulse
	a_restart_pulse: assert property (@(posedge clk) disable iff (!resetn)
		round_restart |=> !round_restart);

endmodule

//--- src/pixel_mux.sv
/*
 * shared pixel port with one cycle of latency from the drawers
 * no back-pressure: the frame buffer must take a pixel every cycle
 */
`timescale 1ns/100ps

module pixel_mux (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          fill_px_valid,
	input  logic [video_pkg::X_W-1:0]     fill_px_x,
	input  logic [video_pkg::Y_W-1:0]     fill_px_y,
	input  logic [video_pkg::COLOR_W-1:0] fill_px_color,
	input  logic                          spr_px_valid,
	input  logic [video_pkg::X_W-1:0]     spr_px_x,
	input  logic [video_pkg::Y_W-1:0]     spr_px_y,
	input  logic [video_pkg::COLOR_W-1:0] spr_px_color,
	output logic [video_pkg::X_W-1:0]     pix_x,
	output logic [video_pkg::Y_W-1:0]     pix_y,
	output logic [video_pkg::COLOR_W-1:0] pix_color,
	output logic                          pix_we
);
	import video_pkg::*;

	logic fill_opaque;
	logic spr_opaque;

	assign fill_opaque = fill_px_valid && (fill_px_color != TRANSPARENT);
	assign spr_opaque  = spr_px_valid && (spr_px_color != TRANSPARENT);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_we <= 1'b0;
		end else begin
			pix_we <= fill_opaque || spr_opaque;
		end
	end

	always_ff @(posedge clk) begin
		if (spr_px_valid) begin
			pix_x     <= spr_px_x;
			pix_y     <= spr_px_y;
			pix_color <= spr_px_color;
		end else begin
			pix_x     <= fill_px_x;
			pix_y     <= fill_px_y;
			pix_color <= fill_px_color;
		end
	end

	// the sequencer runs one drawer at a time
	a_one_source: assert property (@(posedge clk) disable iff (!resetn)
		!(fill_px_valid && spr_px_valid));

endmodule

//--- src/sprite_drawer.sv
/*
 * rasters one object as a SPRITE_SIZE square from its origin, no clipping
 * corner pixels come out transparent; SPRITE_SIZE must be at least 3
 */
`timescale 1ns/100ps

module sprite_drawer #(
	parameter int SPRITE_SIZE = 16
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          spr_req,
	input  logic [game_pkg::OBJ_W-1:0]    obj_word,
	output logic                          spr_ack,
	output logic                          px_valid,
	output logic [video_pkg::X_W-1:0]     px_x,
	output logic [video_pkg::Y_W-1:0]     px_y,
	output logic [video_pkg::COLOR_W-1:0] px_color
);
	import video_pkg::*;
	import game_pkg::*;

	localparam int OFF_W = $clog2(SPRITE_SIZE);
	localparam logic [OFF_W-1:0] OFF_LAST = OFF_W'(SPRITE_SIZE - 1);

	logic              active;
	logic              start;
	logic              last_px;
	logic [X_W-1:0]    org_x;
	logic [Y_W-1:0]    org_y;
	logic [KIND_W-1:0] kind;
	logic [OFF_W-1:0]  dx;
	logic [OFF_W-1:0]  dy;

	assign start   = spr_req && !active && !spr_ack;
	assign last_px = (dx == OFF_LAST) && (dy == OFF_LAST);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active  <= 1'b0;
			spr_ack <= 1'b0;
		end else if (active) begin
			if (last_px) begin
				active  <= 1'b0;
				spr_ack <= 1'b1;
			end
		end else if (start) begin
			active <= 1'b1;
		end else if (!spr_req) begin
			spr_ack <= 1'b0;
		end
	end

	// object fields are captured on the rising request
	always_ff @(posedge clk) begin
		if (start) begin
			org_x <= obj_word[OBJ_X_LSB +: X_W];
			org_y <= obj_word[OBJ_Y_LSB +: Y_W];
			kind  <= obj_word[OBJ_KIND_LSB +: KIND_W];
			dx    <= '0;
			dy    <= '0;
		end else if (active) begin
			if (dx == OFF_LAST) begin
				dx <= '0;
				dy <= dy + 1'b1;
			end else begin
				dx <= dx + 1'b1;
			end
		end
	end

	assign px_valid = active;
	assign px_x     = org_x + X_W'(dx);
	assign px_y     = org_y + Y_W'(dy);

	always_comb begin
		if (sprite_corner(int'(dx), int'(dy), SPRITE_SIZE - 1)) begin
			px_color = TRANSPARENT;
		end else begin
			px_color = kind_color(kind);
		end
	end

endmodule

//--- src/fill_drawer.sv
/*
 * paints the whole screen in one colour, row-major from (0,0)
 * one pixel per cycle under a four-phase req/ack pair
 */
`timescale 1ns/100ps

module fill_drawer #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          fill_req,
	input  logic [video_pkg::COLOR_W-1:0] fill_color,
	output logic                          fill_ack,
	output logic                          px_valid,
	output logic [video_pkg::X_W-1:0]     px_x,
	output logic [video_pkg::Y_W-1:0]     px_y,
	output logic [video_pkg::COLOR_W-1:0] px_color
);
	import video_pkg::*;

	localparam logic [X_W-1:0] X_LAST = X_W'(SCREEN_W - 1);
	localparam logic [Y_W-1:0] Y_LAST = Y_W'(SCREEN_H - 1);

	logic               active;
	logic               start;
	logic               last_px;
	logic [X_W-1:0]     x;
	logic [Y_W-1:0]     y;
	logic [COLOR_W-1:0] color_q;

	// a new request is only taken once the previous ack has dropped
	assign start   = fill_req && !active && !fill_ack;
	assign last_px = (x == X_LAST) && (y == Y_LAST);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active   <= 1'b0;
			fill_ack <= 1'b0;
		end else if (active) begin
			if (last_px) begin
				active   <= 1'b0;
				fill_ack <= 1'b1;
			end
		end else if (start) begin
			active <= 1'b1;
		end else if (!fill_req) begin
			fill_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			x       <= '0;
			y       <= '0;
			color_q <= fill_color;
		end else if (active) begin
			if (x == X_LAST) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign px_valid = active;
	assign px_x     = x;
	assign px_y     = y;
	assign px_color = color_q;

	a_valid_in_req: assert property (@(posedge clk) disable iff (!resetn)
		px_valid |-> fill_req);

endmodule

//--- src/object_table.sv
/*
 * object words with one write port and a combinational read port
 * all entries come out of reset invisible; no writes while a frame is drawn
 */
`timescale 1ns/100ps

module object_table #(
	parameter int N_OBJ = 8,
	localparam int IDX_W = $clog2(N_OBJ)
) (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      obj_we,
	input  logic [IDX_W-1:0]          obj_addr,
	input  logic [game_pkg::OBJ_W-1:0] obj_wdata,
	input  logic [IDX_W-1:0]          obj_index,
	output logic [game_pkg::OBJ_W-1:0] obj_word,
	input  logic                      busy
);
	import game_pkg::*;

	logic [OBJ_W-1:0] words [N_OBJ];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// all-zero word has the visible bit clear
			for (int i = 0; i < N_OBJ; i++) begin
				words[i] <= '0;
			end
		end else if (obj_we) begin
			words[obj_addr] <= obj_wdata;
		end
	end

	assign obj_word = words[obj_index];

	// the sequencer reads the table during the whole frame
	a_no_write_in_frame: assert property (@(posedge clk) disable iff (!resetn)
		busy |-> !obj_we);

endmodule

//--- src/game_pkg.sv
/*
 * game-side constants: object word layout, object kinds and sprite look
 * kind code 3 is not used by the game and draws as stone
 */
package game_pkg;

	localparam int OBJ_W = 32;

	// field positions in the object word
	localparam int OBJ_X_LSB    = 23;
	localparam int OBJ_Y_LSB    = 11;
	localparam int OBJ_KIND_LSB = 2;
	localparam int OBJ_VIS_BIT  = 1;
	localparam int KIND_W       = 2;

	localparam logic [KIND_W-1:0] KIND_GOLD    = 2'd0;
	localparam logic [KIND_W-1:0] KIND_STONE   = 2'd1;
	localparam logic [KIND_W-1:0] KIND_DIAMOND = 2'd2;

	localparam logic [video_pkg::COLOR_W-1:0] GOLD_COLOR    = 12'hFD0;
	localparam logic [video_pkg::COLOR_W-1:0] STONE_COLOR   = 12'h888;
	localparam logic [video_pkg::COLOR_W-1:0] DIAMOND_COLOR = 12'h6EF;

	function automatic logic [video_pkg::COLOR_W-1:0] kind_color(input logic [KIND_W-1:0] kind);
		case (kind)
			KIND_GOLD:    return GOLD_COLOR;
			KIND_DIAMOND: return DIAMOND_COLOR;
			default:      return STONE_COLOR;
		endcase
	endfunction

	// sprites are squares with the four corner pixels cut off
	function automatic logic sprite_corner(input int unsigned dx, input int unsigned dy,
			input int unsigned last);
		return (dx == 0 || dx == last) && (dy == 0 || dy == last);
	endfunction

endpackage

//--- src/video_pkg.sv
/*
 * screen-side constants shared by the drawers and the pixel port
 * colours are 4:4:4 rgb, and colour zero is never written to the frame buffer
 */
package video_pkg;

	// coordinate widths cover the largest supported screen
	localparam int X_W = 9;
	localparam int Y_W = 8;

	localparam int MAX_SCREEN_W = 320;
	localparam int MAX_SCREEN_H = 240;

	localparam int COLOR_W = 12;

	// palette for the full-screen fills
	localparam logic [COLOR_W-1:0] BG_COLOR       = 12'h742;
	localparam logic [COLOR_W-1:0] GAMEOVER_COLOR = 12'h411;

	// pixels of this colour are dropped by the pixel port
	localparam logic [COLOR_W-1:0] TRANSPARENT    = 12'h000;

endpackage
